//--- Bender.yml
package:
  name: lake_tile

sources:
  - files:
      - rtl/tile_params_pkg.sv
      - rtl/access_pattern_pkg.sv
      - rtl/mem_port_if.sv
      - rtl/loop_nest.sv
      - rtl/affine_addr_gen.sv
      - rtl/access_scheduler.sv
      - rtl/write_controller.sv
      - rtl/read_controller.sv
      - rtl/accum_buffer.sv
      - rtl/lake_tile.sv
  - target: simulation
    files:
      - dv/tb_lake_tile.sv

//--- dv/tb_lake_tile.sv
module tb_lake_tile import tile_params_pkg::*, access_pattern_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_W    = DEF_DATA_W;
  localparam int MEM_DEPTH = DEF_MEM_DEPTH;
  localparam int RUN_LIMIT = 2000;    // Cycles allowed for one pattern pair.
  localparam int QUIET     = 40;      // Idle cycles watched after the last read.

  logic              clk = 1'b0;
  logic              rst_n;
  logic              clk_en;
  logic              flush;
  logic [DATA_W-1:0] data_in;
  logic [DATA_W-1:0] data_out;
  logic              data_valid;

  // Index 0 is the write side, index 1 the read side.
  dim_count_t c_dims     [2];
  dim_cfg_t   c_ranges   [2];
  dim_cfg_t   c_strides  [2];
  dim_cfg_t   c_sstrides [2];
  cfg_word_t  c_start    [2];
  cfg_word_t  c_sstart   [2];

  logic [DATA_W-1:0] m_mem [MEM_DEPTH];
  cfg_word_t         m_cyc;
  cfg_word_t         m_cnt  [2][NUM_DIMS];
  cfg_word_t         m_aoff [2];
  cfg_word_t         m_soff [2];
  bit                m_gate [2];
  bit                exp_valid;
  logic [DATA_W-1:0] exp_data;

  int          errors;
  int          checks;
  int          valid_seen;

  always #5 clk = ~clk;

  lake_tile #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .clk_en            (clk_en),
    .flush             (flush),
    .data_in           (data_in),
    .wr_dimensionality (c_dims[0]),
    .wr_ranges         (c_ranges[0]),
    .wr_strides        (c_strides[0]),
    .wr_sched_strides  (c_sstrides[0]),
    .wr_start_addr     (c_start[0]),
    .wr_sched_start    (c_sstart[0]),
    .rd_dimensionality (c_dims[1]),
    .rd_ranges         (c_ranges[1]),
    .rd_strides        (c_strides[1]),
    .rd_sched_strides  (c_sstrides[1]),
    .rd_start_addr     (c_start[1]),
    .rd_sched_start    (c_sstart[1]),
    .data_out          (data_out),
    .data_valid        (data_valid)
  );

  task automatic clear_model();
    m_cyc = '0;
    for (int s = 0; s < 2; s++) begin
      m_aoff[s] = '0;
      m_soff[s] = '0;
      m_gate[s] = 1'b1;
      for (int i = 0; i < NUM_DIMS; i++) begin
        m_cnt[s][i] = '0;
      end
    end
  endtask

  // Predicts the strobes of the cycle whose inputs were just driven.
  task automatic predict_cycle(input bit en, input bit fl);
    int        act  [2];
    bit        fire [2];
    int        addr [2];
    cfg_word_t due;
    for (int s = 0; s < 2; s++) begin
      act[s] = -1;
      for (int i = NUM_DIMS - 1; i >= 0; i--) begin
        if (i < c_dims[s] && m_cnt[s][i] != c_ranges[s][i]) begin
          act[s] = i;    // Lowest unfinished dimension wins.
        end
      end
      due     = c_sstart[s] + m_soff[s];
      fire[s] = m_gate[s] && en && !fl && (m_cyc == due);
      addr[s] = (c_start[s] + m_aoff[s]) % MEM_DEPTH;
    end
    exp_valid = fire[1];
    if (fire[1]) begin
      exp_data = m_mem[addr[1]];    // Old word on a same-cycle write.
    end
    if (fire[0]) begin
      m_mem[addr[0]] = data_in;
    end
    if (en && fl) begin
      clear_model();
    end else if (en) begin
      m_cyc++;
      for (int s = 0; s < 2; s++) begin
        if (fire[s] && act[s] < 0) begin
          clear_model_side(s);
        end else if (fire[s]) begin
          for (int i = 0; i < act[s]; i++) begin
            m_cnt[s][i] = '0;
          end
          m_cnt[s][act[s]]++;
          m_aoff[s] += c_strides[s][act[s]];
          m_soff[s] += c_sstrides[s][act[s]];
        end
      end
    end
  endtask

  // Last access of a side. Counters return to zero and the side goes silent.
  task automatic clear_model_side(input int s);
    m_aoff[s] = '0;
    m_soff[s] = '0;
    m_gate[s] = 1'b0;
    for (int i = 0; i < NUM_DIMS; i++) begin
      m_cnt[s][i] = '0;
    end
  endtask

  // Checks the previous edge, drives the next cycle and advances to its falling edge.
  task automatic run_cycle(input bit en, input bit fl);
    checks++;
    assert (data_valid === exp_valid) else begin
      errors++;
      $display("FAILED at %0t: data_valid is %b, expected %b", $time, data_valid, exp_valid);
    end
    if (exp_valid) begin
      checks++;
      assert (data_out === exp_data) else begin
        errors++;
        $display("FAILED at %0t: data_out is %h, expected %h", $time, data_out, exp_data);
      end
    end
    if (data_valid === 1'b1) begin
      valid_seen++;
    end
    clk_en  = en;
    flush   = fl;
    data_in = {$urandom, $urandom};
    predict_cycle(en, fl);
    @(negedge clk);
  endtask

  function automatic bit pick_enable(input bit stall);
    return !stall || ($urandom % 4 != 0);    // About one cycle in four stalls.
  endfunction

  task automatic set_linear_config();
    for (int s = 0; s < 2; s++) begin
      c_dims[s]        = 4'd1;
      c_ranges[s]      = '0;
      c_ranges[s][0]   = MEM_DEPTH - 1;
      c_strides[s]     = '0;
      c_strides[s][0]  = 1;
      c_sstrides[s]    = '0;
      c_sstrides[s][0] = 1;
      c_start[s]       = '0;
    end
    c_sstart[0] = '0;
    c_sstart[1] = MEM_DEPTH + 5;
  endtask

  // Read side walks the write addresses on its own random schedule.
  task automatic randomize_config();
    int total;
    total = 1;
    c_dims[0] = dim_count_t'(1 + $urandom % 4);
    for (int i = 0; i < NUM_DIMS; i++) begin
      c_ranges[0][i]   = $urandom % 3;
      c_strides[0][i]  = $urandom % 8;
      c_sstrides[0][i] = 1 + $urandom % 3;
      c_sstrides[1][i] = 1 + $urandom % 3;
      if (i < c_dims[0]) begin
        total *= c_ranges[0][i] + 1;
      end
    end
    c_start[0]   = $urandom % 256;
    c_sstart[0]  = $urandom % 8;
    c_dims[1]    = c_dims[0];
    c_ranges[1]  = c_ranges[0];
    c_strides[1] = c_strides[0];
    c_start[1]   = c_start[0];
    c_sstart[1]  = c_sstart[0] + 3 * total + $urandom % 4;    // After the last write.
  endtask

  task automatic run_pattern(input bit stall, input int abort_after);
    int expected;
    int waited;
    expected = 1;
    for (int i = 0; i < NUM_DIMS; i++) begin
      if (i < c_dims[1]) begin
        expected *= c_ranges[1][i] + 1;
      end
    end
    run_cycle(1'b1, 1'b1);
    valid_seen = 0;
    if (abort_after > 0) begin
      repeat (abort_after) run_cycle(pick_enable(stall), 1'b0);
    end else begin
      waited = 0;
      while (valid_seen < expected && waited < RUN_LIMIT) begin
        run_cycle(pick_enable(stall), 1'b0);
        waited++;
      end
      assert (waited < RUN_LIMIT) else begin
        errors++;
        $display("Timed out waiting for read data: %0d of %0d words came back",
                 valid_seen, expected);
      end
      repeat (QUIET) run_cycle(pick_enable(stall), 1'b0);
      checks++;
      assert (valid_seen == expected) else begin
        errors++;
        $display("FAILED at %0t: %0d valid pulses, expected %0d", $time, valid_seen, expected);
      end
    end
  endtask

  initial begin
    void'($urandom(32'ha29d));
    rst_n     = 1'b0;
    clk_en    = 1'b0;
    flush     = 1'b0;
    data_in   = '0;
    errors    = 0;
    checks    = 0;
    exp_valid = 1'b0;
    exp_data  = '0;
    for (int s = 0; s < 2; s++) begin
      c_dims[s]     = '0;
      c_ranges[s]   = '0;
      c_strides[s]  = '0;
      c_sstrides[s] = '0;
      c_start[s]    = '0;
      c_sstart[s]   = '0;
    end
    clear_model();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    set_linear_config();    // Fills the whole buffer.
    run_pattern(1'b0, 0);
    repeat (4) begin
      randomize_config();
      run_pattern(1'b0, 0);
    end
    set_linear_config();
    run_pattern(1'b0, 30);    // Flushed in mid-pattern.
    randomize_config();
    run_pattern(1'b0, 0);
    repeat (2) begin
      randomize_config();
      run_pattern(1'b1, 0);
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_lake_tile

//--- rtl/access_pattern_pkg.sv
package access_pattern_pkg;

  import tile_params_pkg::*;

  // One configuration word.
  typedef logic [CFG_W-1:0] cfg_word_t;

  // Per-dimension words, used for ranges and strides.
  typedef logic [NUM_DIMS-1:0][CFG_W-1:0] dim_cfg_t;

  // Index of the active dimension.
  typedef logic [$clog2(NUM_DIMS)-1:0] dim_sel_t;

  // Number of dimensions in use.
  typedef logic [3:0] dim_count_t;

endpackage : access_pattern_pkg

//--- rtl/access_scheduler.sv
module access_scheduler import access_pattern_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      clk_en,
  input  logic      flush,
  input  logic      finished,
  input  dim_sel_t  dim_sel,
  input  cfg_word_t sched_start,
  input  dim_cfg_t  sched_strides,
  output logic      step
);

  cfg_word_t cycle_cnt;
  cfg_word_t sched_time;
  logic      gate_open;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else if (clk_en) begin
      if (flush) begin
        cycle_cnt <= '0;
      end else begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
    end
  end

  // The gate shuts on the last access and stays shut until flush.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gate_open <= 1'b1;
    end else if (clk_en) begin
      if (flush) begin
        gate_open <= 1'b1;
      end else if (step && finished) begin
        gate_open <= 1'b0;
      end
    end
  end

  assign step = gate_open && clk_en && !flush && (cycle_cnt == sched_time);

  affine_addr_gen u_sched_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_en  (clk_en),
    .flush   (flush),
    .step    (step),
    .restart (finished),
    .dim_sel (dim_sel),
    .start   (sched_start),
    .strides (sched_strides),
    .addr    (sched_time)
  );

endmodule : access_scheduler

//--- rtl/accum_buffer.sv
module accum_buffer import tile_params_pkg::*; #(
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_DEPTH = DEF_MEM_DEPTH
) (
  input logic     clk,
  mem_port_if.mem mem
);

  logic [DATA_W-1:0] ram [MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      ram[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Same-address read and write returns the old word.
  always_ff @(posedge clk) begin
    if (mem.rd_en) begin
      mem.rd_data <= ram[mem.rd_addr];
    end
  end

endmodule : accum_buffer

//--- rtl/affine_addr_gen.sv
module affine_addr_gen import access_pattern_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      clk_en,
  input  logic      flush,
  input  logic      step,
  input  logic      restart,
  input  dim_sel_t  dim_sel,
  input  cfg_word_t start,
  input  dim_cfg_t  strides,
  output cfg_word_t addr
);

  cfg_word_t offset;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (clk_en) begin
      if (flush) begin
        offset <= '0;
      end else if (step) begin
        if (restart) begin
          offset <= '0;    // Pattern wrapped.
        end else begin
          offset <= offset + strides[dim_sel];
        end
      end
    end
  end

  assign addr = start + offset;

endmodule : affine_addr_gen

//--- rtl/lake_tile.sv
module lake_tile import tile_params_pkg::*, access_pattern_pkg::*; #(
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_DEPTH = DEF_MEM_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clk_en,
  input  logic              flush,
  input  logic [DATA_W-1:0] data_in,
  input  dim_count_t        wr_dimensionality,
  input  dim_cfg_t          wr_ranges,
  input  dim_cfg_t          wr_strides,
  input  dim_cfg_t          wr_sched_strides,
  input  cfg_word_t         wr_start_addr,
  input  cfg_word_t         wr_sched_start,
  input  dim_count_t        rd_dimensionality,
  input  dim_cfg_t          rd_ranges,
  input  dim_cfg_t          rd_strides,
  input  dim_cfg_t          rd_sched_strides,
  input  cfg_word_t         rd_start_addr,
  input  cfg_word_t         rd_sched_start,
  output logic [DATA_W-1:0] data_out,
  output logic              data_valid
);

  mem_port_if #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) mem_bus ();

  write_controller #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) u_writer (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_en         (clk_en),
    .flush          (flush),
    .data_in        (data_in),
    .dimensionality (wr_dimensionality),
    .ranges         (wr_ranges),
    .strides        (wr_strides),
    .sched_strides  (wr_sched_strides),
    .start_addr     (wr_start_addr),
    .sched_start    (wr_sched_start),
    .mem            (mem_bus.writer)
  );

  accum_buffer #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) u_buffer (
    .clk (clk),
    .mem (mem_bus.mem)
  );

  read_controller #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) u_reader (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_en         (clk_en),
    .flush          (flush),
    .dimensionality (rd_dimensionality),
    .ranges         (rd_ranges),
    .strides        (rd_strides),
    .sched_strides  (rd_sched_strides),
    .start_addr     (rd_start_addr),
    .sched_start    (rd_sched_start),
    .mem            (mem_bus.reader),
    .data_out       (data_out),
    .data_valid     (data_valid)
  );

endmodule : lake_tile

//--- rtl/loop_nest.sv
module loop_nest import tile_params_pkg::*, access_pattern_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clk_en,
  input  logic       flush,
  input  logic       step,
  input  dim_count_t dimensionality,
  input  dim_cfg_t   ranges,
  output dim_sel_t   dim_sel,
  output logic       finished
);

  dim_cfg_t            count;
  logic [NUM_DIMS-1:0] at_max;

  // Dimensions beyond the configured count behave as if already at maximum.
  always_comb begin
    for (int i = 0; i < NUM_DIMS; i++) begin
      at_max[i] = (count[i] == ranges[i]) || (dimensionality <= i);
    end
  end

  // Lowest dimension that can still advance.
  always_comb begin
    dim_sel = '0;
    for (int i = NUM_DIMS - 1; i >= 0; i--) begin
      if (!at_max[i]) begin
        dim_sel = dim_sel_t'(i);
      end
    end
  end

  assign finished = &at_max;    // The current access is the last one.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clk_en) begin
      if (flush) begin
        count <= '0;
      end else if (step) begin
        for (int i = 0; i < NUM_DIMS; i++) begin
          if (finished || (i < dim_sel)) begin
            count[i] <= '0;    // Inner dimensions wrap.
          end else if (i == dim_sel) begin
            count[i] <= count[i] + 1'b1;
          end
        end
      end
    end
  end

endmodule : loop_nest

//--- rtl/mem_port_if.sv
interface mem_port_if import tile_params_pkg::*; #(
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_DEPTH = DEF_MEM_DEPTH
);

  localparam int ADDR_W = $clog2(MEM_DEPTH);

  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;    // Valid the cycle after rd_en.

  modport writer (output wr_en, output wr_addr, output wr_data);

  modport reader (output rd_en, output rd_addr, input rd_data);

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface : mem_port_if

//--- rtl/read_controller.sv
module read_controller import tile_params_pkg::*, access_pattern_pkg::*; #(
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_DEPTH = DEF_MEM_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clk_en,
  input  logic              flush,
  input  dim_count_t        dimensionality,
  input  dim_cfg_t          ranges,
  input  dim_cfg_t          strides,
  input  dim_cfg_t          sched_strides,
  input  cfg_word_t         start_addr,
  input  cfg_word_t         sched_start,
  mem_port_if.reader        mem,
  output logic [DATA_W-1:0] data_out,
  output logic              data_valid
);

  localparam int ADDR_W = $clog2(MEM_DEPTH);

  dim_sel_t  dim_sel;
  logic      finished;
  logic      step;
  cfg_word_t addr;

  loop_nest u_loop (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_en         (clk_en),
    .flush          (flush),
    .step           (step),
    .dimensionality (dimensionality),
    .ranges         (ranges),
    .dim_sel        (dim_sel),
    .finished       (finished)
  );

  affine_addr_gen u_addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_en  (clk_en),
    .flush   (flush),
    .step    (step),
    .restart (finished),
    .dim_sel (dim_sel),
    .start   (start_addr),
    .strides (strides),
    .addr    (addr)
  );

  access_scheduler u_sched (
    .clk           (clk),
    .rst_n         (rst_n),
    .clk_en        (clk_en),
    .flush         (flush),
    .finished      (finished),
    .dim_sel       (dim_sel),
    .sched_start   (sched_start),
    .sched_strides (sched_strides),
    .step          (step)
  );

  assign mem.rd_en   = step;
  assign mem.rd_addr = addr[ADDR_W-1:0];

  // One pulse per read, aligned with the registered buffer output.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_valid <= 1'b0;
    end else begin
      data_valid <= mem.rd_en;
    end
  end

  assign data_out = mem.rd_data;

endmodule : read_controller

//--- rtl/tile_params_pkg.sv
package tile_params_pkg;

  // Loop dimensions supported by each access pattern.
  parameter int NUM_DIMS = 6;

  // Width of range, stride and start words and of the cycle count.
  parameter int CFG_W = 16;

  // Default buffer geometry.
  parameter int DEF_DATA_W    = 64;
  parameter int DEF_MEM_DEPTH = 64;

endpackage : tile_params_pkg

//--- rtl/write_controller.sv
module write_controller import tile_params_pkg::*, access_pattern_pkg::*; #(
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_DEPTH = DEF_MEM_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clk_en,
  input  logic              flush,
  input  logic [DATA_W-1:0] data_in,
  input  dim_count_t        dimensionality,
  input  dim_cfg_t          ranges,
  input  dim_cfg_t          strides,
  input  dim_cfg_t          sched_strides,
  input  cfg_word_t         start_addr,
  input  cfg_word_t         sched_start,
  mem_port_if.writer        mem
);

  localparam int ADDR_W = $clog2(MEM_DEPTH);

  dim_sel_t  dim_sel;
  logic      finished;
  logic      step;
  cfg_word_t addr;

  loop_nest u_loop (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_en         (clk_en),
    .flush          (flush),
    .step           (step),
    .dimensionality (dimensionality),
    .ranges         (ranges),
    .dim_sel        (dim_sel),
    .finished       (finished)
  );

  affine_addr_gen u_addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_en  (clk_en),
    .flush   (flush),
    .step    (step),
    .restart (finished),
    .dim_sel (dim_sel),
    .start   (start_addr),
    .strides (strides),
    .addr    (addr)
  );

  access_scheduler u_sched (
    .clk           (clk),
    .rst_n         (rst_n),
    .clk_en        (clk_en),
    .flush         (flush),
    .finished      (finished),
    .dim_sel       (dim_sel),
    .sched_start   (sched_start),
    .sched_strides (sched_strides),
    .step          (step)
  );

  assign mem.wr_en   = step;
  assign mem.wr_addr = addr[ADDR_W-1:0];    // Wraps modulo depth.
  assign mem.wr_data = data_in;

endmodule : write_controller

//--- sim.f
rtl/tile_params_pkg.sv
rtl/access_pattern_pkg.sv
rtl/mem_port_if.sv
rtl/loop_nest.sv
rtl/affine_addr_gen.sv
rtl/access_scheduler.sv
rtl/write_controller.sv
rtl/read_controller.sv
rtl/accum_buffer.sv
rtl/lake_tile.sv
dv/tb_lake_tile.sv
